//--- design/direct_cache.sv
`default_nettype none
`timescale 1ns/1ps
`include "tsc_params.svh"

module direct_cache #(
	parameter int NUM_LINES = `CACHE_LINES
) (
	input wire Clk,
	input wire rst_n,
	input wire tsc_pkg::word_t address,
	input wire rd_en,
	input wire wr_en,
	input wire tsc_pkg::word_t wdata,
	output tsc_pkg::word_t rdata,
	output logic hit,
	output logic req_read,
	output logic req_write,
	output tsc_pkg::word_t req_addr,
	output tsc_pkg::word_t req_wdata,
	input wire grant,
	input wire read_ack,
	input wire write_ack,
	input wire tsc_pkg::line_t fill_line
);
	import tsc_pkg::*;

	localparam int OFS_W = $clog2(`LINE_WORDS);
	localparam int IDX_W = $clog2(NUM_LINES);
	localparam int TAG_W = `WORD_SIZE - OFS_W - IDX_W;

	cache_state_t state;
	logic write_done;
	logic fill_done;
	logic store_done;

	logic [OFS_W-1:0] ofs;
	logic [IDX_W-1:0] idx;
	logic [TAG_W-1:0] tag;
	logic tag_hit;

	logic [NUM_LINES-1:0] valid;
	logic [TAG_W-1:0] tags [NUM_LINES];
	line_t lines [NUM_LINES];

	assign ofs = address[OFS_W-1:0];
	assign idx = address[OFS_W +: IDX_W];
	assign tag = address[`WORD_SIZE-1 -: TAG_W];
	assign tag_hit = valid[idx] && (tags[idx] == tag);

	assign rdata = lines[idx][ofs * `WORD_SIZE +: `WORD_SIZE];
	// Reads answer combinationally, writes one cycle after their ack
	assign hit = (state == READY && rd_en && tag_hit) || write_done;

	assign req_read = (state == FILL);
	assign req_write = (state == WRITE);
	assign req_addr = req_read ? {address[`WORD_SIZE-1:OFS_W], {OFS_W{1'b0}}} : address;
	assign req_wdata = wdata;

	// Acks only count while this cache owns the bus
	assign fill_done = req_read && grant && read_ack;
	assign store_done = req_write && grant && write_ack;

	always_ff @(posedge Clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= READY;
			write_done <= 1'b0;
		end else begin
			write_done <= store_done;
			case (state)
				READY: begin
					if (rd_en && !tag_hit)
						state <= FILL;
					else if (wr_en && !write_done)
						state <= WRITE;
				end
				FILL: if (fill_done) state <= READY;
				WRITE: if (store_done) state <= READY;
				default: state <= READY;
			endcase
		end
	end

	always_ff @(posedge Clk or negedge rst_n) begin
		if (!rst_n)
			valid <= '0;
		else if (fill_done)
			valid[idx] <= 1'b1;
	end

	always_ff @(posedge Clk) begin
		if (fill_done) begin
			lines[idx] <= fill_line;
			tags[idx] <= tag;
		end else if (store_done && tag_hit) begin
			// Write-through keeps a resident line current
			lines[idx][ofs * `WORD_SIZE +: `WORD_SIZE] <= wdata;
		end
	end

	no_dual_request: assert property (@(posedge Clk) disable iff (!rst_n)
		!(req_read && req_write));

endmodule

`default_nettype wire

//--- design/mem_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

module mem_arbiter (
	input wire Clk,
	input wire rst_n,
	input wire i_req_read,
	input wire tsc_pkg::word_t i_req_addr,
	output logic i_grant,
	input wire d_req_read,
	input wire d_req_write,
	input wire tsc_pkg::word_t d_req_addr,
	input wire tsc_pkg::word_t d_req_wdata,
	output logic d_grant,
	output logic mem_read,
	output logic mem_write,
	output tsc_pkg::word_t mem_addr,
	output tsc_pkg::word_t mem_wdata
);
	import tsc_pkg::*;

	bus_owner_t owner;
	bus_owner_t owner_next;
	logic d_req;

	assign d_req = d_req_read || d_req_write;

	// Instruction side wins when both ask from idle
	always_comb begin
		owner_next = owner;
		case (owner)
			IDLE: begin
				if (i_req_read)
					owner_next = INST;
				else if (d_req)
					owner_next = DATA;
			end
			INST: if (!i_req_read) owner_next = IDLE;
			DATA: if (!d_req) owner_next = IDLE;
			default: owner_next = IDLE;
		endcase
	end

	always_ff @(posedge Clk or negedge rst_n) begin
		if (!rst_n)
			owner <= IDLE;
		else
			owner <= owner_next;
	end

	assign i_grant = (owner == INST);
	assign d_grant = (owner == DATA);

	assign mem_read = (i_grant && i_req_read) || (d_grant && d_req_read);
	assign mem_write = d_grant && d_req_write;
	assign mem_addr = d_grant ? d_req_addr : i_req_addr;
	assign mem_wdata = d_req_wdata;

	single_owner: assert property (@(posedge Clk) disable iff (!rst_n)
		!(i_grant && d_grant));

endmodule

`default_nettype wire

//--- design/tsc_core.sv
`default_nettype none
`timescale 1ns/1ps
`include "tsc_params.svh"

module tsc_core (
	input wire Clk,
	input wire rst_n,
	output tsc_pkg::word_t i_addr,
	output logic i_rd_en,
	input wire tsc_pkg::word_t i_data,
	input wire i_hit,
	output tsc_pkg::word_t d_addr,
	output tsc_pkg::word_t d_wdata,
	output logic d_rd_en,
	output logic d_wr_en,
	input wire tsc_pkg::word_t d_rdata,
	input wire d_hit,
	output tsc_pkg::word_t num_inst,
	output tsc_pkg::word_t output_port,
	output logic is_halted
);
	import tsc_pkg::*;

	word_t pc;
	logic halt_seen;
	logic inst_stall;
	logic data_stall;
	logic stall;
	logic retire;

	logic fe_valid;
	word_t fe_inst;

	opcode_t de_op;
	funct_t de_funct;
	reg_idx_t de_rs;
	reg_idx_t de_rt;
	reg_idx_t de_rd;
	reg_idx_t de_dest;
	word_t de_imm;
	word_t rs_val;
	word_t rt_val;
	word_t alu_out;
	logic de_reg_write;
	logic de_load;
	logic de_store;
	logic de_wwd;
	logic de_hlt;

	logic xw_valid;
	word_t xw_result;
	word_t xw_store_data;
	reg_idx_t xw_dest;
	logic xw_reg_write;
	logic xw_load;
	logic xw_store;
	logic xw_wwd;
	logic xw_hlt;
	word_t wb_value;

	word_t regs [`NUM_REGS];

	assign de_op = opcode_t'(fe_inst[15:12]);
	assign de_funct = funct_t'(fe_inst[5:0]);
	assign de_rs = fe_inst[11:10];
	assign de_rt = fe_inst[9:8];
	assign de_rd = fe_inst[7:6];
	assign de_imm = {{(`WORD_SIZE - 8){fe_inst[7]}}, fe_inst[7:0]};

	// Writeback result bypassed into decode/execute
	assign wb_value = xw_load ? d_rdata : xw_result;
	assign rs_val = (xw_valid && xw_reg_write && xw_dest == de_rs) ? wb_value : regs[de_rs];
	assign rt_val = (xw_valid && xw_reg_write && xw_dest == de_rt) ? wb_value : regs[de_rt];

	always_comb begin
		alu_out = rs_val + de_imm;
		de_dest = de_rt;
		de_reg_write = 1'b0;
		de_load = 1'b0;
		de_store = 1'b0;
		de_wwd = 1'b0;
		de_hlt = 1'b0;
		case (de_op)
			ADI: de_reg_write = 1'b1;
			LHI: begin
				alu_out = {fe_inst[7:0], 8'h00};
				de_reg_write = 1'b1;
			end
			LWD: begin
				de_load = 1'b1;
				de_reg_write = 1'b1;
			end
			SWD: de_store = 1'b1;
			RTYPE: begin
				de_dest = de_rd;
				case (de_funct)
					ADD: begin
						alu_out = rs_val + rt_val;
						de_reg_write = 1'b1;
					end
					SUB: begin
						alu_out = rs_val - rt_val;
						de_reg_write = 1'b1;
					end
					AND: begin
						alu_out = rs_val & rt_val;
						de_reg_write = 1'b1;
					end
					ORR: begin
						alu_out = rs_val | rt_val;
						de_reg_write = 1'b1;
					end
					WWD: begin
						alu_out = rs_val;
						de_wwd = 1'b1;
					end
					HLT: de_hlt = 1'b1;
					default: ;
				endcase
			end
			default: ;
		endcase
	end

	// Stop fetching as soon as HLT shows up in decode
	assign i_addr = pc;
	assign i_rd_en = !halt_seen && !(fe_valid && de_hlt);

	assign d_addr = xw_result;
	assign d_wdata = xw_store_data;
	assign d_rd_en = xw_valid && xw_load;
	assign d_wr_en = xw_valid && xw_store;

	assign inst_stall = i_rd_en && !i_hit;
	assign data_stall = (d_rd_en || d_wr_en) && !d_hit;
	assign stall = inst_stall || data_stall;
	assign retire = xw_valid && !stall;

	always_ff @(posedge Clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
			halt_seen <= 1'b0;
			fe_valid <= 1'b0;
			xw_valid <= 1'b0;
		end else if (!stall) begin
			if (i_rd_en)
				pc <= pc + 1'b1;
			fe_valid <= i_rd_en;
			xw_valid <= fe_valid;
			if (fe_valid && de_hlt)
				halt_seen <= 1'b1;
		end
	end

	always_ff @(posedge Clk) begin
		if (!stall) begin
			fe_inst <= i_data;
			xw_result <= alu_out;
			xw_store_data <= rt_val;
			xw_dest <= de_dest;
			xw_reg_write <= de_reg_write;
			xw_load <= de_load;
			xw_store <= de_store;
			xw_wwd <= de_wwd;
			xw_hlt <= de_hlt;
		end
	end

	always_ff @(posedge Clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `NUM_REGS; i++)
				regs[i] <= '0;
		end else if (retire && xw_reg_write) begin
			regs[xw_dest] <= wb_value;
		end
	end

	always_ff @(posedge Clk or negedge rst_n) begin
		if (!rst_n) begin
			num_inst <= '0;
			output_port <= '0;
			is_halted <= 1'b0;
		end else if (retire) begin
			num_inst <= num_inst + 1'b1;
			if (xw_wwd)
				output_port <= xw_result;
			if (xw_hlt)
				is_halted <= 1'b1;
		end
	end

	pc_hold_on_miss: assert property (@(posedge Clk) disable iff (!rst_n)
		!i_hit |=> $stable(pc));

endmodule

`default_nettype wire

//--- design/tsc_pkg.sv
`default_nettype none
`include "tsc_params.svh"

package tsc_pkg;

	typedef logic [`WORD_SIZE-1:0] word_t;
	// Word 0 sits in the low bits
	typedef logic [`LINE_BITS-1:0] line_t;
	typedef logic [1:0] reg_idx_t;

	typedef enum logic [3:0] {
		ADI = 4'd4,
		LHI = 4'd6,
		LWD = 4'd7,
		SWD = 4'd8,
		RTYPE = 4'd15
	} opcode_t;

	typedef enum logic [5:0] {
		ADD = 6'd0,
		SUB = 6'd1,
		AND = 6'd2,
		ORR = 6'd3,
		WWD = 6'd28,
		HLT = 6'd29
	} funct_t;

	typedef enum logic [1:0] {
		IDLE,
		INST,
		DATA
	} bus_owner_t;

	typedef enum logic [1:0] {
		READY,
		FILL,
		WRITE
	} cache_state_t;

endpackage

`default_nettype wire

//--- design/tsc_top.sv
`default_nettype none
`timescale 1ns/1ps
`include "tsc_params.svh"

module tsc_top (
	input wire Clk,
	input wire rst_n,
	output logic mem_read,
	output logic mem_write,
	output tsc_pkg::word_t mem_addr,
	output tsc_pkg::word_t mem_wdata,
	input wire tsc_pkg::line_t mem_line,
	input wire read_ack,
	input wire write_ack,
	output tsc_pkg::word_t num_inst,
	output tsc_pkg::word_t output_port,
	output logic is_halted
);
	import tsc_pkg::*;

	word_t i_addr;
	word_t i_data;
	logic i_rd_en;
	logic i_hit;
	word_t d_addr;
	word_t d_wdata;
	word_t d_rdata;
	logic d_rd_en;
	logic d_wr_en;
	logic d_hit;

	logic i_req_read;
	word_t i_req_addr;
	logic i_grant;
	logic d_req_read;
	logic d_req_write;
	word_t d_req_addr;
	word_t d_req_wdata;
	logic d_grant;

	tsc_core core (
		.Clk(Clk),
		.rst_n(rst_n),
		.i_addr(i_addr),
		.i_rd_en(i_rd_en),
		.i_data(i_data),
		.i_hit(i_hit),
		.d_addr(d_addr),
		.d_wdata(d_wdata),
		.d_rd_en(d_rd_en),
		.d_wr_en(d_wr_en),
		.d_rdata(d_rdata),
		.d_hit(d_hit),
		.num_inst(num_inst),
		.output_port(output_port),
		.is_halted(is_halted)
	);

	// Instruction side never writes
	direct_cache #(.NUM_LINES(`CACHE_LINES)) inst_cache (
		.Clk(Clk),
		.rst_n(rst_n),
		.address(i_addr),
		.rd_en(i_rd_en),
		.wr_en(1'b0),
		.wdata('0),
		.rdata(i_data),
		.hit(i_hit),
		.req_read(i_req_read),
		.req_write(),
		.req_addr(i_req_addr),
		.req_wdata(),
		.grant(i_grant),
		.read_ack(read_ack),
		.write_ack(write_ack),
		.fill_line(mem_line)
	);

	direct_cache #(.NUM_LINES(`CACHE_LINES)) data_cache (
		.Clk(Clk),
		.rst_n(rst_n),
		.address(d_addr),
		.rd_en(d_rd_en),
		.wr_en(d_wr_en),
		.wdata(d_wdata),
		.rdata(d_rdata),
		.hit(d_hit),
		.req_read(d_req_read),
		.req_write(d_req_write),
		.req_addr(d_req_addr),
		.req_wdata(d_req_wdata),
		.grant(d_grant),
		.read_ack(read_ack),
		.write_ack(write_ack),
		.fill_line(mem_line)
	);

	mem_arbiter arbiter (
		.Clk(Clk),
		.rst_n(rst_n),
		.i_req_read(i_req_read),
		.i_req_addr(i_req_addr),
		.i_grant(i_grant),
		.d_req_read(d_req_read),
		.d_req_write(d_req_write),
		.d_req_addr(d_req_addr),
		.d_req_wdata(d_req_wdata),
		.d_grant(d_grant),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata)
	);

endmodule

`default_nettype wire

//--- include/tsc_params.svh
`ifndef TSC_PARAMS_SVH
`define TSC_PARAMS_SVH

// Data and address width
`define WORD_SIZE 16

// Words per cache line
`define LINE_WORDS 4
`define LINE_BITS (`WORD_SIZE * `LINE_WORDS)

// Lines per cache unless a cache overrides it
`define CACHE_LINES 8

// Architectural registers
`define NUM_REGS 4

`endif

//--- run_tsc.sh
#!/bin/sh
# Build with Verilator and run; the status follows the testbench result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_tsc -f tsc.f &&
./obj_dir/Vtb_tsc | tee /dev/stderr | grep -q "All tests passed" &&
echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

//--- testbench/tb_memory.sv
`default_nettype none
`timescale 1ns/1ps

module tb_memory #(
	parameter int LATENCY = 3,
	parameter int MEM_WORDS = 1024
) (
	input wire Clk,
	input wire rst_n,
	input wire mem_read,
	input wire mem_write,
	input wire tsc_pkg::word_t mem_addr,
	input wire tsc_pkg::word_t mem_wdata,
	output tsc_pkg::line_t mem_line = '0,
	output logic read_ack = 1'b0,
	output logic write_ack = 1'b0
);
	import tsc_pkg::*;

	word_t mem [MEM_WORDS];

	logic busy;
	logic is_write;
	int count;
	word_t addr_q;
	word_t data_q;

	// One request at a time, answered LATENCY cycles after it is seen
	always @(negedge Clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			count <= 0;
			read_ack <= 1'b0;
			write_ack <= 1'b0;
		end else begin
			read_ack <= 1'b0;
			write_ack <= 1'b0;
			if (!busy) begin
				if (mem_read || mem_write) begin
					busy <= 1'b1;
					count <= LATENCY;
					is_write <= mem_write;
					addr_q <= mem_addr;
					data_q <= mem_wdata;
				end
			end else if (count > 1) begin
				count <= count - 1;
			end else begin
				busy <= 1'b0;
				if (is_write) begin
					mem[addr_q % MEM_WORDS] <= data_q;
					write_ack <= 1'b1;
				end else begin
					for (int k = 0; k < 4; k++)
						mem_line[k * 16 +: 16] <= mem[(addr_q + k) % MEM_WORDS];
					read_ack <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- testbench/tb_tsc.sv
`default_nettype none
`timescale 1ns/1ps

module tb_tsc;
	import tsc_pkg::*;

	localparam int PROG_LEN = 60;
	localparam int DATA_BASE = 256;
	localparam int DATA_WORDS = 64;
	localparam int MEM_WORDS = 1024;
	localparam int CYCLE = 100;
	localparam int LIMIT_CYCLES = 2 * PROG_LEN * 40 + 200;

	logic Clk;
	logic rst_n;
	logic mem_read;
	logic mem_write;
	word_t mem_addr;
	word_t mem_wdata;
	line_t mem_line;
	logic read_ack;
	logic write_ack;
	word_t num_inst;
	word_t output_port;
	logic is_halted;

	int errors;
	int checks;
	int n;
	logic [31:0] lcg_state;
	word_t last_num;

	word_t prog [PROG_LEN];
	word_t model_regs [4];
	word_t model_mem [DATA_WORDS];
	word_t model_port;
	word_t exp_port [PROG_LEN + 1];
	int exp_retired;

	tsc_top uut (
		.Clk(Clk),
		.rst_n(rst_n),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_line(mem_line),
		.read_ack(read_ack),
		.write_ack(write_ack),
		.num_inst(num_inst),
		.output_port(output_port),
		.is_halted(is_halted)
	);

	tb_memory #(.LATENCY(3), .MEM_WORDS(MEM_WORDS)) mem_model (
		.Clk(Clk),
		.rst_n(rst_n),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_line(mem_line),
		.read_ack(read_ack),
		.write_ack(write_ack)
	);

	initial Clk = 1'b0;
	always #(CYCLE / 2) Clk = ~Clk;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic int rand_below(input int limit);
		logic [31:0] r;
		r = lcg_next() >> 16;
		return int'(r % 32'(limit));
	endfunction

	// Initial memory word built from every address bit
	function automatic word_t init_word(input int addr);
		logic [31:0] v;
		v = 32'(addr) * 32'd40503 ^ 32'h5a5a;
		return v[15:0] ^ v[31:16];
	endfunction

	function automatic word_t enc_imm(input logic [3:0] op, input reg_idx_t rs,
			input reg_idx_t rt, input logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t enc_reg(input reg_idx_t rs, input reg_idx_t rt,
			input reg_idx_t rd, input logic [5:0] funct);
		return {4'hf, rs, rt, rd, funct};
	endfunction

	task automatic check_word(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
		end
	endtask

	// Instruction-set model executing one instruction
	task automatic execute(input word_t inst);
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t rd;
		word_t imm;
		word_t addr;
		rs = inst[11:10];
		rt = inst[9:8];
		rd = inst[7:6];
		imm = {{8{inst[7]}}, inst[7:0]};
		addr = model_regs[rs] + imm;
		case (inst[15:12])
			ADI: model_regs[rt] = model_regs[rs] + imm;
			LHI: model_regs[rt] = {inst[7:0], 8'h00};
			LWD: model_regs[rt] = model_mem[int'(addr) - DATA_BASE];
			SWD: model_mem[int'(addr) - DATA_BASE] = model_regs[rt];
			4'hf: begin
				case (inst[5:0])
					ADD: model_regs[rd] = model_regs[rs] + model_regs[rt];
					SUB: model_regs[rd] = model_regs[rs] - model_regs[rt];
					AND: model_regs[rd] = model_regs[rs] & model_regs[rt];
					ORR: model_regs[rd] = model_regs[rs] | model_regs[rt];
					WWD: model_port = model_regs[rs];
					default: ;
				endcase
			end
			default: ;
		endcase
		exp_retired++;
		exp_port[exp_retired] = model_port;
	endtask

	task automatic emit(input word_t inst);
		prog[n] = inst;
		execute(inst);
		n++;
	endtask

	// Mode 1 keeps to a few addresses so stores hit resident lines
	task automatic gen_program(input int mode);
		int kind;
		int target;
		int diff;
		reg_idx_t rs;
		reg_idx_t rt;
		int small_set [6];
		small_set = '{0, 1, 2, 3, 32, 35};
		for (int i = 0; i < 4; i++)
			model_regs[i] = '0;
		for (int i = 0; i < DATA_WORDS; i++)
			model_mem[i] = init_word(DATA_BASE + i);
		model_port = '0;
		exp_retired = 0;
		exp_port[0] = '0;
		n = 0;
		while (n < PROG_LEN - 1) begin
			kind = rand_below(10);
			rs = reg_idx_t'(rand_below(4));
			rt = reg_idx_t'(rand_below(4));
			if (mode == 1 && kind > 2 && kind < 7)
				kind = 2;
			if (kind == 0) begin
				emit(enc_imm(ADI, rs, rt, 8'(rand_below(256))));
			end else if (kind == 1) begin
				emit(enc_imm(LHI, 2'd0, rt, 8'(rand_below(256))));
			end else if (kind == 2 || kind == 3) begin
				if (mode == 1)
					target = DATA_BASE + small_set[rand_below(6)];
				else
					target = DATA_BASE + rand_below(DATA_WORDS);
				diff = target - int'(model_regs[rs]);
				if (diff < -128 || diff > 127) begin
					if (n < PROG_LEN - 2) begin
						emit(enc_imm(LHI, 2'd0, rs, 8'h01));
						diff = target - DATA_BASE;
					end
				end
				if (diff >= -128 && diff <= 127) begin
					if (rand_below(2) == 0)
						emit(enc_imm(LWD, rs, rt, 8'(diff)));
					else
						emit(enc_imm(SWD, rs, rt, 8'(diff)));
				end
			end else if (kind < 8) begin
				emit(enc_reg(rs, rt, reg_idx_t'(rand_below(4)), 6'(rand_below(4))));
			end else begin
				emit(enc_reg(rs, 2'd0, 2'd0, WWD));
			end
		end
		emit(enc_reg(2'd0, 2'd0, 2'd0, HLT));
	endtask

	task automatic run_program(input int mode);
		gen_program(mode);
		for (int i = 0; i < MEM_WORDS; i++)
			mem_model.mem[i] = init_word(i);
		for (int i = 0; i < PROG_LEN; i++)
			mem_model.mem[i] = prog[i];
		@(negedge Clk);
		rst_n = 1'b0;
		last_num = '0;
		repeat (2) @(negedge Clk);
		rst_n = 1'b1;
		while (!is_halted)
			@(negedge Clk);
		check_word("num_inst", num_inst, word_t'(exp_retired));
		repeat (20) begin
			@(negedge Clk);
			check_bit("is_halted", is_halted, 1'b1);
		end
		for (int i = 0; i < DATA_WORDS; i++)
			check_word($sformatf("mem[%0h]", DATA_BASE + i),
				mem_model.mem[DATA_BASE + i], model_mem[i]);
	endtask

	// Bus rules and retire stream checked on the falling edge
	always @(negedge Clk) begin
		if (rst_n) begin
			check_bit("mem_read & mem_write", mem_read && mem_write, 1'b0);
			if (mem_read)
				check_word("mem_addr[1:0]", mem_addr & 16'h0003, 16'h0000);
			if (num_inst != last_num) begin
				check_word("num_inst", num_inst, last_num + 16'd1);
				if (int'(num_inst) <= PROG_LEN)
					check_word("output_port", output_port, exp_port[num_inst]);
				last_num = num_inst;
			end
		end
	end

	initial begin
		#(LIMIT_CYCLES * CYCLE);
		$display("Timeout: the core did not halt in time");
		$display("Some tests failed");
		$finish;
	end

	initial begin
		errors = 0;
		checks = 0;
		rst_n = 1'b0;
		last_num = '0;
		lcg_state = 32'h4ea9;
		run_program(0);
		run_program(1);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tsc.f
+incdir+include
design/tsc_pkg.sv
design/direct_cache.sv
design/mem_arbiter.sv
design/tsc_core.sv
design/tsc_top.sv
testbench/tb_memory.sv
testbench/tb_tsc.sv
